// File: bt_air_pkg.sv
`default_nettype none

// air-interface side: access-code sync words and captured payloads
package bt_air_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // access-code sync word length
  localparam int SYNC_BITS = 64;

  // capture register width, upper bound of the payload length
  localparam int MAX_CAPTURE_BITS = 32;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // one sync word, or the window of the last SYNC_BITS received bits
  typedef logic [SYNC_BITS-1:0] sync_word_t;

  // agreeing positions, 0 up to SYNC_BITS inclusive
  typedef logic [$clog2(SYNC_BITS+1)-1:0] match_count_t;

  // payload word taken after a sync hit, first bit in bit 0
  typedef logic [MAX_CAPTURE_BITS-1:0] capture_word_t;

endpackage

`default_nettype wire

// File: bt_regs_pkg.sv
`default_nettype none

// host side: AXI4-Lite widths, responses and the register map
package bt_regs_pkg;

  localparam int AXIL_ADDR_BITS = 8;
  localparam int AXIL_DATA_BITS = 32;

  typedef logic [AXIL_ADDR_BITS-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_BITS-1:0] axil_data_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // byte offsets of the registers
  typedef enum axil_addr_t {
    REG_CTRL    = 8'h00,
    REG_THRESH  = 8'h04,
    REG_SYNC_LO = 8'h08,
    REG_SYNC_HI = 8'h0C,
    REG_STATUS  = 8'h10,
    REG_CAPTURE = 8'h14
  } reg_addr_e;

  // field positions
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_CLEAR_BIT  = 1;
  localparam int STATUS_DONE_BIT = 0;
  localparam int STATUS_HITS_LSB = 8;
  localparam int HIT_COUNT_BITS  = 8;

  // allows four mismatching sync bits out of 64
  localparam int THRESH_RESET = 60;

endpackage

`default_nettype wire

// File: rx_bit_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module rx_bit_sampler #(
  parameter int CYCLES_PER_BIT = 6
) (
  input  wire  clk_6M,
  input  wire  rstz,
  input  wire  rxbit,
  output logic bit_valid,
  output logic bit_data
);

  localparam int CNT_BITS = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;

  logic [1:0]          rx_sync;
  logic [CNT_BITS-1:0] cycle_cnt;
  logic                tick;

  // rxbit comes from outside the clock domain
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_sync <= 2'b00;
    else
      rx_sync <= {rx_sync[0], rxbit};
  end

  ////////////////////////////////////////////////////////////////////////////
  // bit period strobe, free running from reset release
  ////////////////////////////////////////////////////////////////////////////

  assign tick = (cycle_cnt == CNT_BITS'(CYCLES_PER_BIT - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      cycle_cnt <= '0;
    else if (tick)
      cycle_cnt <= '0;
    else
      cycle_cnt <= cycle_cnt + 1'b1;
  end

  // one sample per period, whatever the input phase
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bit_valid <= 1'b0;
    else
      bit_valid <= tick;
  end

  always_ff @(posedge clk_6M)
  begin
    if (tick)
      bit_data <= rx_sync[1];
  end

endmodule

`default_nettype wire

// File: sync_correlator.sv
`timescale 1ns/1ns
`default_nettype none

module sync_correlator (
  input  wire                      clk_6M,
  input  wire                      rstz,
  input  wire                      bit_valid,
  input  wire                      bit_data,
  input  wire                      enable,
  input  wire                      busy,
  input  wire bt_air_pkg::match_count_t threshold,
  input  wire bt_air_pkg::sync_word_t   sync_word,
  output logic                     sync_hit
);

  import bt_air_pkg::*;

  sync_word_t   window;
  match_count_t match_count;
  logic         shifted;
  logic         count_valid;

  // number of positions where the two words agree
  function automatic match_count_t count_matches(sync_word_t a, sync_word_t b);
    sync_word_t   agree;
    match_count_t total;
    agree = ~(a ^ b);
    total = '0;
    for (int i = 0; i < SYNC_BITS; i++)
    begin
      total = total + match_count_t'(agree[i]);
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sliding window
  ////////////////////////////////////////////////////////////////////////////

  // new bits enter at the top, so the oldest one ends up in bit 0
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      window <= '0;
    else if (bit_valid)
      window <= {bit_data, window[SYNC_BITS-1:1]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // match count and hit decision
  ////////////////////////////////////////////////////////////////////////////

  // count stage lags the window by one cycle
  always_ff @(posedge clk_6M)
  begin
    if (shifted)
      match_count <= count_matches(window, sync_word);
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      shifted     <= 1'b0;
      count_valid <= 1'b0;
      sync_hit    <= 1'b0;
    end
    else
    begin
      shifted     <= bit_valid;
      count_valid <= shifted;
      // no new hit while a payload is being taken or held
      sync_hit    <= count_valid & enable & ~busy & (match_count >= threshold);
    end
  end

endmodule

`default_nettype wire

// File: payload_capture.sv
`timescale 1ns/1ns
`default_nettype none

module payload_capture #(
  parameter int CAPTURE_BITS = 32
) (
  input  wire                        clk_6M,
  input  wire                        rstz,
  input  wire                        bit_valid,
  input  wire                        bit_data,
  input  wire                        sync_hit,
  input  wire                        clear,
  output logic                       busy,
  output logic                       done,
  output bt_air_pkg::capture_word_t  capture_word
);

  import bt_air_pkg::*;

  localparam int IDX_BITS = $clog2(MAX_CAPTURE_BITS);

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_COLLECT,
    CAP_HOLD
  } cap_state_e;

  cap_state_e          state;
  logic [IDX_BITS-1:0] bit_cnt;
  capture_word_t       payload_reg;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state       <= CAP_IDLE;
      bit_cnt     <= '0;
      payload_reg <= '0;
    end
    else if (clear)
      state <= CAP_IDLE;
    else
    begin
      case (state)
        CAP_IDLE:
          if (sync_hit)
          begin
            state       <= CAP_COLLECT;
            bit_cnt     <= '0;
            payload_reg <= '0;
          end
        CAP_COLLECT:
          if (bit_valid)
          begin
            // first payload bit goes to bit 0
            payload_reg[bit_cnt] <= bit_data;
            if (bit_cnt == IDX_BITS'(CAPTURE_BITS - 1))
              state <= CAP_HOLD;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        default:
          // result stays until the host clears it
          state <= CAP_HOLD;
      endcase
    end
  end

  assign busy         = (state != CAP_IDLE);
  assign done         = (state == CAP_HOLD);
  assign capture_word = payload_reg;

endmodule

`default_nettype wire

// File: axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_regs (
  input  wire                            clk_6M,
  input  wire                            rstz,
  input  wire                            awvalid,
  output logic                           awready,
  input  wire bt_regs_pkg::axil_addr_t   awaddr,
  input  wire                            wvalid,
  output logic                           wready,
  input  wire bt_regs_pkg::axil_data_t   wdata,
  output logic                           bvalid,
  input  wire                            bready,
  output bt_regs_pkg::axi_resp_e         bresp,
  input  wire                            arvalid,
  output logic                           arready,
  input  wire bt_regs_pkg::axil_addr_t   araddr,
  output logic                           rvalid,
  input  wire                            rready,
  output bt_regs_pkg::axil_data_t        rdata,
  output bt_regs_pkg::axi_resp_e         rresp,
  input  wire                            sync_hit,
  input  wire                            done,
  input  wire bt_air_pkg::capture_word_t capture_word,
  output logic                           enable,
  output logic                           clear,
  output bt_air_pkg::match_count_t       threshold,
  output bt_air_pkg::sync_word_t         sync_word
);

  import bt_air_pkg::*;
  import bt_regs_pkg::*;

  logic                      aw_held;
  logic                      w_held;
  axil_addr_t                aw_addr_q;
  axil_data_t                w_data_q;
  logic                      aw_fire;
  logic                      w_fire;
  logic                      wr_go;
  axil_addr_t                wr_addr;
  axil_data_t                wr_data;
  axi_resp_e                 wr_resp;
  logic                      ar_fire;
  axil_data_t                rd_data;
  axi_resp_e                 rd_resp;
  logic [HIT_COUNT_BITS-1:0] hit_count;

  ////////////////////////////////////////////////////////////////////////////
  // write channels
  ////////////////////////////////////////////////////////////////////////////

  assign awready = ~aw_held & ~bvalid;
  assign wready  = ~w_held & ~bvalid;
  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;

  // address and data may come in either order, or together
  assign wr_go   = (aw_held | aw_fire) & (w_held | w_fire);
  assign wr_addr = aw_held ? aw_addr_q : awaddr;
  assign wr_data = w_held ? w_data_q : wdata;

  always_comb
  begin
    case (reg_addr_e'(wr_addr))
      REG_CTRL, REG_THRESH, REG_SYNC_LO, REG_SYNC_HI: wr_resp = RESP_OKAY;
      default:                                        wr_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_6M)
  begin
    if (aw_fire)
      aw_addr_q <= awaddr;
    if (w_fire)
      w_data_q <= wdata;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= RESP_OKAY;
      enable    <= 1'b0;
      clear     <= 1'b0;
      threshold <= match_count_t'(THRESH_RESET);
      sync_word <= '0;
    end
    else
    begin
      clear <= 1'b0;
      if (wr_go)
      begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        bvalid  <= 1'b1;
        bresp   <= wr_resp;
        case (reg_addr_e'(wr_addr))
          REG_CTRL:
          begin
            enable <= wr_data[CTRL_ENABLE_BIT];
            clear  <= wr_data[CTRL_CLEAR_BIT];
          end
          REG_THRESH:  threshold <= wr_data[$bits(match_count_t)-1:0];
          REG_SYNC_LO: sync_word[AXIL_DATA_BITS-1:0] <= wr_data;
          REG_SYNC_HI: sync_word[SYNC_BITS-1:AXIL_DATA_BITS] <= wr_data;
          default:     ;
        endcase
      end
      else
      begin
        if (aw_fire)
          aw_held <= 1'b1;
        if (w_fire)
          w_held <= 1'b1;
        if (bready)
          bvalid <= 1'b0;
      end
    end
  end

  // saturating count of detected sync words
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hit_count <= '0;
    else if (clear)
      hit_count <= '0;
    else if (sync_hit && hit_count != '1)
      hit_count <= hit_count + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////////////////////

  assign arready = ~rvalid;
  assign ar_fire = arvalid & arready;

  always_comb
  begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (reg_addr_e'(araddr))
      REG_CTRL:    rd_data[CTRL_ENABLE_BIT] = enable;
      REG_THRESH:  rd_data[$bits(match_count_t)-1:0] = threshold;
      REG_SYNC_LO: rd_data = sync_word[AXIL_DATA_BITS-1:0];
      REG_SYNC_HI: rd_data = sync_word[SYNC_BITS-1:AXIL_DATA_BITS];
      REG_STATUS:
      begin
        rd_data[STATUS_DONE_BIT]                   = done;
        rd_data[STATUS_HITS_LSB +: HIT_COUNT_BITS] = hit_count;
      end
      REG_CAPTURE: rd_data = capture_word;
      default:     rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end
    else if (ar_fire)
    begin
      rvalid <= 1'b1;
      rdata  <= rd_data;
      rresp  <= rd_resp;
    end
    else if (rready)
      rvalid <= 1'b0;
  end

endmodule

`default_nettype wire

// File: bt_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module bt_rx_top #(
  parameter int CYCLES_PER_BIT = 6,
  parameter int CAPTURE_BITS   = 32
) (
  input  wire                          clk_6M,
  input  wire                          rstz,
  input  wire                          rxbit,
  input  wire                          awvalid,
  output logic                         awready,
  input  wire bt_regs_pkg::axil_addr_t awaddr,
  input  wire                          wvalid,
  output logic                         wready,
  input  wire bt_regs_pkg::axil_data_t wdata,
  output logic                         bvalid,
  input  wire                          bready,
  output bt_regs_pkg::axi_resp_e       bresp,
  input  wire                          arvalid,
  output logic                         arready,
  input  wire bt_regs_pkg::axil_addr_t araddr,
  output logic                         rvalid,
  input  wire                          rready,
  output bt_regs_pkg::axil_data_t      rdata,
  output bt_regs_pkg::axi_resp_e       rresp
);

  import bt_air_pkg::*;

  logic          bit_valid;
  logic          bit_data;
  logic          enable;
  logic          clear;
  logic          sync_hit;
  logic          busy;
  logic          done;
  match_count_t  threshold;
  sync_word_t    sync_word;
  capture_word_t capture_word;

  ////////////////////////////////////////////////////////////////////////////
  // receive path
  ////////////////////////////////////////////////////////////////////////////

  rx_bit_sampler #(
    .CYCLES_PER_BIT (CYCLES_PER_BIT)
  ) i_rx_bit_sampler (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .rxbit     (rxbit),
    .bit_valid (bit_valid),
    .bit_data  (bit_data)
  );

  sync_correlator i_sync_correlator (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .bit_valid (bit_valid),
    .bit_data  (bit_data),
    .enable    (enable),
    .busy      (busy),
    .threshold (threshold),
    .sync_word (sync_word),
    .sync_hit  (sync_hit)
  );

  payload_capture #(
    .CAPTURE_BITS (CAPTURE_BITS)
  ) i_payload_capture (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .bit_valid    (bit_valid),
    .bit_data     (bit_data),
    .sync_hit     (sync_hit),
    .clear        (clear),
    .busy         (busy),
    .done         (done),
    .capture_word (capture_word)
  );

  // host register port
  axil_regs i_axil_regs (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .awvalid      (awvalid),
    .awready      (awready),
    .awaddr       (awaddr),
    .wvalid       (wvalid),
    .wready       (wready),
    .wdata        (wdata),
    .bvalid       (bvalid),
    .bready       (bready),
    .bresp        (bresp),
    .arvalid      (arvalid),
    .arready      (arready),
    .araddr       (araddr),
    .rvalid       (rvalid),
    .rready       (rready),
    .rdata        (rdata),
    .rresp        (rresp),
    .sync_hit     (sync_hit),
    .done         (done),
    .capture_word (capture_word),
    .enable       (enable),
    .clear        (clear),
    .threshold    (threshold),
    .sync_word    (sync_word)
  );

endmodule

`default_nettype wire

// File: tb_bt_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bt_rx;

  import bt_air_pkg::*;
  import bt_regs_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 5;
  localparam int CYCLES_PER_BIT = 6;
  localparam int CAPTURE_BITS   = 32;
  localparam int IDLE_BITS      = 16;
  localparam int POLL_LIMIT     = 40;
  localparam int NUM_FRAMES     = 7;
  localparam int BIT_NS         = CYCLES_PER_BIT * CLK_PERIOD;
  localparam int WATCHDOG_NS    = NUM_FRAMES * 130 * BIT_NS;

  logic       clk_6M;
  logic       rstz;
  logic       rxbit;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  axil_data_t wdata;
  logic       bvalid;
  logic       bready;
  axi_resp_e  bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  axil_data_t rdata;
  axi_resp_e  rresp;

  logic [63:0] rng_state;
  logic [7:0]  exp_hits;
  int          error_count;
  int          tests_run;
  int          tests_bad;

  bt_rx_top #(
    .CYCLES_PER_BIT (CYCLES_PER_BIT),
    .CAPTURE_BITS   (CAPTURE_BITS)
  ) i_bt_rx_top (
    .clk_6M  (clk_6M),
    .rstz    (rstz),
    .rxbit   (rxbit),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  initial
  begin
    clk_6M = 1'b0;
    forever #(CLK_PERIOD / 2) clk_6M = ~clk_6M;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t ns, the tests did not complete", $time);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // n distinct sync positions, stepping by 7 mod 64
  function automatic sync_word_t flip_mask(input int n);
    sync_word_t m;
    m = '0;
    for (int i = 0; i < n; i++)
    begin
      m[(i * 7) % SYNC_BITS] = 1'b1;
    end
    return m;
  endfunction

  // done in bit 0, hit count in 15:8
  function automatic axil_data_t status_value(input logic done_bit, input logic [7:0] hits);
    axil_data_t v;
    v       = '0;
    v[0]    = done_bit;
    v[15:8] = hits;
    return v;
  endfunction

  task automatic next_cycle();
    @(posedge clk_6M);
    #(DRIVE_DELAY);
  endtask

  task automatic draw_frame_data(output sync_word_t sw, output capture_word_t pl);
    rng_state = xorshift64(rng_state);
    sw        = rng_state;
    rng_state = xorshift64(rng_state);
    pl        = rng_state[31:0];
  endtask

  task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s = %s, expected %s", $time, name, got.name(), exp.name());
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////////////////////////////////////////

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output axi_resp_e resp);
    logic aw_acc;
    logic w_acc;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (awvalid || wvalid)
    begin
      // ready seen now means the transfer at the coming edge
      aw_acc = awvalid & awready;
      w_acc  = wvalid & wready;
      next_cycle();
      if (aw_acc)
        awvalid = 1'b0;
      if (w_acc)
        wvalid = 1'b0;
    end
    while (!bvalid)
      next_cycle();
    resp = bresp;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axi_resp_e resp);
    logic ar_acc;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (arvalid)
    begin
      ar_acc = arready;
      next_cycle();
      if (ar_acc)
        arvalid = 1'b0;
    end
    while (!rvalid)
      next_cycle();
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                           input axi_resp_e exp_resp, input string name);
    axi_resp_e resp;
    axil_write(addr, data, resp);
    check_resp({"bresp ", name}, resp, exp_resp);
  endtask

  task automatic read_check(input axil_addr_t addr, input axil_data_t exp, input string name);
    axil_data_t data;
    axi_resp_e  resp;
    axil_read(addr, data, resp);
    check_resp({"rresp ", name}, resp, RESP_OKAY);
    check_data({"rdata ", name}, data, exp);
  endtask

  task automatic program_sync(input sync_word_t sw);
    write_reg(REG_SYNC_LO, sw[31:0], RESP_OKAY, "REG_SYNC_LO");
    write_reg(REG_SYNC_HI, sw[63:32], RESP_OKAY, "REG_SYNC_HI");
  endtask

  // clear pulse with enable kept on
  task automatic clear_capture();
    write_reg(REG_CTRL, 32'h3, RESP_OKAY, "REG_CTRL");
    exp_hits = 8'd0;
  endtask

  task automatic wait_done();
    axil_data_t status;
    axi_resp_e  resp;
    int         polls;
    polls = 0;
    axil_read(REG_STATUS, status, resp);
    while (!status[0] && polls < POLL_LIMIT)
    begin
      polls++;
      axil_read(REG_STATUS, status, resp);
    end
    if (!status[0])
    begin
      $display("ERROR at %0t ns: capture never finished within %0d status reads",
               $time, POLL_LIMIT + 1);
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // serial frames
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_bits(input logic bits[$]);
    foreach (bits[i])
    begin
      rxbit = bits[i];
      repeat (CYCLES_PER_BIT) next_cycle();
    end
    rxbit = 1'b0;
  endtask

  // idle zeros, sync word with n bits flipped, payload, two settling bits
  task automatic send_frame(input sync_word_t sw, input int n_flips, input capture_word_t pl);
    logic       bits[$];
    sync_word_t on_air;
    on_air = sw ^ flip_mask(n_flips);
    for (int i = 0; i < IDLE_BITS; i++)
      bits.push_back(1'b0);
    for (int i = 0; i < SYNC_BITS; i++)
      bits.push_back(on_air[i]);
    for (int i = 0; i < CAPTURE_BITS; i++)
      bits.push_back(pl[i]);
    bits.push_back(1'b0);
    bits.push_back(1'b0);
    send_bits(bits);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before)
      $display("%0t ns  %-18s ok", $time, name);
    else
    begin
      tests_bad++;
      $display("%0t ns  %-18s FAILED with %0d errors", $time, name,
               error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_register_access();
    int         errors_before;
    axil_data_t data;
    axi_resp_e  resp;
    errors_before = error_count;
    read_check(REG_THRESH, axil_data_t'(THRESH_RESET), "REG_THRESH");
    write_reg(REG_THRESH, 32'h2A, RESP_OKAY, "REG_THRESH");
    read_check(REG_THRESH, 32'h2A, "REG_THRESH");
    rng_state = xorshift64(rng_state);
    write_reg(REG_SYNC_LO, rng_state[31:0], RESP_OKAY, "REG_SYNC_LO");
    read_check(REG_SYNC_LO, rng_state[31:0], "REG_SYNC_LO");
    write_reg(REG_SYNC_HI, rng_state[63:32], RESP_OKAY, "REG_SYNC_HI");
    read_check(REG_SYNC_HI, rng_state[63:32], "REG_SYNC_HI");
    // clear reads back as 0
    write_reg(REG_CTRL, 32'h2, RESP_OKAY, "REG_CTRL");
    read_check(REG_CTRL, 32'h0, "REG_CTRL");
    write_reg(8'h18, 32'hFFFF_FFFF, RESP_SLVERR, "unmapped 0x18");
    axil_read(8'h18, data, resp);
    check_resp("rresp unmapped 0x18", resp, RESP_SLVERR);
    write_reg(REG_CAPTURE, 32'h1234_5678, RESP_SLVERR, "REG_CAPTURE");
    read_check(REG_CAPTURE, 32'h0, "REG_CAPTURE");
    write_reg(REG_STATUS, 32'hFFFF_FFFF, RESP_SLVERR, "REG_STATUS");
    read_check(REG_STATUS, status_value(1'b0, 8'd0), "REG_STATUS");
    finish_test("register_access", errors_before);
  endtask

  task automatic test_exact_match();
    int            errors_before;
    sync_word_t    sw;
    capture_word_t pl;
    errors_before = error_count;
    draw_frame_data(sw, pl);
    write_reg(REG_THRESH, 32'd60, RESP_OKAY, "REG_THRESH");
    program_sync(sw);
    write_reg(REG_CTRL, 32'h1, RESP_OKAY, "REG_CTRL");
    send_frame(sw, 0, pl);
    wait_done();
    exp_hits = 8'd1;
    read_check(REG_CAPTURE, pl, "REG_CAPTURE");
    read_check(REG_STATUS, status_value(1'b1, exp_hits), "REG_STATUS");
    clear_capture();
    read_check(REG_STATUS, status_value(1'b0, exp_hits), "REG_STATUS");
    finish_test("exact_match", errors_before);
  endtask

  task automatic test_error_tolerance();
    int            errors_before;
    int            thresh;
    sync_word_t    sw;
    capture_word_t pl;
    errors_before = error_count;
    thresh        = 56;
    draw_frame_data(sw, pl);
    write_reg(REG_THRESH, axil_data_t'(thresh), RESP_OKAY, "REG_THRESH");
    program_sync(sw);
    // exactly at the threshold
    send_frame(sw, SYNC_BITS - thresh, pl);
    wait_done();
    exp_hits = 8'd1;
    read_check(REG_CAPTURE, pl, "REG_CAPTURE");
    read_check(REG_STATUS, status_value(1'b1, exp_hits), "REG_STATUS");
    clear_capture();
    // one error too many
    send_frame(sw, SYNC_BITS - thresh + 1, pl);
    read_check(REG_STATUS, status_value(1'b0, exp_hits), "REG_STATUS");
    finish_test("error_tolerance", errors_before);
  endtask

  task automatic test_disabled();
    int            errors_before;
    sync_word_t    sw;
    capture_word_t pl;
    errors_before = error_count;
    draw_frame_data(sw, pl);
    write_reg(REG_THRESH, 32'd60, RESP_OKAY, "REG_THRESH");
    write_reg(REG_CTRL, 32'h0, RESP_OKAY, "REG_CTRL");
    program_sync(sw);
    send_frame(sw, 0, pl);
    read_check(REG_STATUS, status_value(1'b0, exp_hits), "REG_STATUS");
    finish_test("disabled", errors_before);
  endtask

  task automatic test_hold_and_clear();
    int            errors_before;
    sync_word_t    sw;
    capture_word_t pl_a;
    capture_word_t pl_b;
    errors_before = error_count;
    draw_frame_data(sw, pl_a);
    rng_state = xorshift64(rng_state);
    pl_b      = rng_state[31:0];
    write_reg(REG_CTRL, 32'h1, RESP_OKAY, "REG_CTRL");
    program_sync(sw);
    send_frame(sw, 0, pl_a);
    wait_done();
    exp_hits = 8'd1;
    read_check(REG_CAPTURE, pl_a, "REG_CAPTURE");
    // second frame lost while the first is held
    send_frame(sw, 0, pl_b);
    read_check(REG_STATUS, status_value(1'b1, exp_hits), "REG_STATUS");
    read_check(REG_CAPTURE, pl_a, "REG_CAPTURE");
    clear_capture();
    read_check(REG_STATUS, status_value(1'b0, exp_hits), "REG_STATUS");
    draw_frame_data(sw, pl_a);
    program_sync(sw);
    send_frame(sw, 0, pl_a);
    wait_done();
    exp_hits = 8'd1;
    read_check(REG_CAPTURE, pl_a, "REG_CAPTURE");
    read_check(REG_STATUS, status_value(1'b1, exp_hits), "REG_STATUS");
    finish_test("hold_and_clear", errors_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rstz        = 1'b0;
    rxbit       = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    rng_state   = 64'd63;
    exp_hits    = 8'd0;
    error_count = 0;
    tests_run   = 0;
    tests_bad   = 0;

    repeat (10) next_cycle();
    rstz = 1'b1;
    next_cycle();

    test_register_access();
    test_exact_match();
    test_error_tolerance();
    test_disabled();
    test_hold_and_clear();

    $display("%0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_bad, error_count);
    if (error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bt_rx.f
bt_air_pkg.sv
bt_regs_pkg.sv
rx_bit_sampler.sv
sync_correlator.sv
payload_capture.sv
axil_regs.sv
bt_rx_top.sv
tb_bt_rx.sv

// File: Makefile
TOP = tb_bt_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) \
		-f bt_rx.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
